// ==== bench/spdif_rx_assert.sv ====
`timescale 1ns/1ps

module spdif_rx_assert (
    input logic       clk,
    input logic       rst,
    input logic       ack_i,
    input logic       locked_i,
    input logic       rd_i,
    input logic [3:0] count_i,
    input logic       bclk_i,
    input logic       ws_i
);

    ack_when_locked: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> locked_i)
        else $error("sample strobe while the decoder is unlocked");

    no_empty_read: assert property (@(posedge clk) disable iff (rst)
        !(rd_i && count_i == 4'd0))
        else $error("fifo popped while empty");

    // ws moves together with the bclk falling edge
    ws_on_fall: assert property (@(posedge clk) disable iff (rst)
        (ws_i != $past(ws_i)) |-> (!bclk_i && $past(bclk_i)))
        else $error("word select changed away from a falling bit clock");

endmodule

bind spdif_rx_top spdif_rx_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .ack_i    (dai_ack),
    .locked_i (locked_o),
    .rd_i     (fifo_rd),
    .count_i  (fifo_count),
    .bclk_i   (bclk_o),
    .ws_i     (ws_o)
);

// ==== bench/spdif_source.sv ====
`timescale 1ns/1ps

module spdif_source (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [spdif_pkg::HALFBIT_W-1:0] halfbit_i,
    input  logic                            valid_i,
    input  spdif_pkg::preamble_e            pre_i,
    input  logic [23:0]                     audio_i,
    input  logic                            u_i,
    input  logic                            c_i,
    output logic                            take_o,
    output logic                            line_o
);

    logic [63:0]                     next_hb;
    logic [63:0]                     hb_sr;
    logic [6:0]                      hb_left;
    logic [spdif_pkg::HALFBIT_W-1:0] clk_left;

    // one subframe as 64 line levels, first half-bit in the msb
    function automatic logic [63:0] encode(input spdif_pkg::preamble_e pre,
                                           input logic [23:0] audio,
                                           input logic u,
                                           input logic c,
                                           input logic level);
        logic [7:0]  pat;
        logic [27:0] slots;
        logic [63:0] hb;
        logic        lvl;
        case (pre)
            spdif_pkg::PRE_B: pat = 8'b1110_1000;
            spdif_pkg::PRE_M: pat = 8'b1110_0010;
            default:          pat = 8'b1110_0100;
        endcase
        if (level) begin
            pat = ~pat;  // preamble opens with a line toggle
        end
        hb[63:56] = pat;
        lvl = pat[0];
        slots = {^{audio, u, c}, c, u, 1'b0, audio};  // slot 31 down to slot 4, v = 0
        for (int i = 0; i < 28; i++) begin
            lvl = ~lvl;  // every cell starts with a transition
            hb[55-2*i] = lvl;
            if (slots[i]) begin
                lvl = ~lvl;
            end
            hb[54-2*i] = lvl;
        end
        return hb;
    endfunction

    assign next_hb = encode(pre_i, audio_i, u_i, c_i, line_o);

    // back to back subframes, the line holds its level when nothing is queued
    always_ff @(posedge clk) begin
        if (rst) begin
            line_o   <= 1'b0;
            take_o   <= 1'b0;
            hb_sr    <= '0;
            hb_left  <= '0;
            clk_left <= '0;
        end else begin
            take_o <= 1'b0;
            if (clk_left != '0) begin
                clk_left <= clk_left - 1'b1;
            end else if (hb_left != '0) begin
                line_o   <= hb_sr[63];
                hb_sr    <= {hb_sr[62:0], 1'b0};
                hb_left  <= hb_left - 1'b1;
                clk_left <= halfbit_i - 1'b1;
            end else if (valid_i) begin
                line_o   <= next_hb[63];
                hb_sr    <= {next_hb[62:0], 1'b0};
                hb_left  <= 7'd63;
                clk_left <= halfbit_i - 1'b1;
                take_o   <= 1'b1;
            end
        end
    end

endmodule

// ==== bench/tb_spdif_rx.sv ====
`timescale 1ns/1ps

module tb_spdif_rx;

    localparam int NUM_ROWS = spdif_pkg::BLOCK_FRAMES + 1;  // one block plus the next B
    localparam int WAIT_LIMIT = 2000;                       // clocks per encoder handoff
    localparam int DRAIN_LIMIT = 10000;
    localparam int HALFBIT_CLKS = 4;
    localparam int SUBFRAME_CLKS = spdif_pkg::SUBFRAME_HALFBITS * HALFBIT_CLKS;
    // last subframe still on the line, then one idle subframe
    localparam int UNLOCK_LIMIT = 2 * SUBFRAME_CLKS;
    localparam int I2S_FRAME_CLKS = 2 * audio_pkg::I2S_SLOT_W * 2 * audio_pkg::BCLK_DIV;

    logic                               clk;
    logic                               rst;
    logic                               line;
    logic [spdif_pkg::HALFBIT_W-1:0]    halfbit;
    logic                               locked;
    logic                               overflow;
    logic [spdif_pkg::BLOCK_FRAMES-1:0] udata;
    logic [spdif_pkg::BLOCK_FRAMES-1:0] cdata;
    logic                               bclk;
    logic                               ws;
    logic                               sdata;

    logic                 src_valid;
    spdif_pkg::preamble_e src_pre;
    logic [23:0]          src_audio;
    logic                 src_u;
    logic                 src_c;
    logic                 src_take;

    // stimulus table
    string       row_name  [NUM_ROWS];
    logic [23:0] row_left  [NUM_ROWS];
    logic [23:0] row_right [NUM_ROWS];
    logic        row_u     [NUM_ROWS];
    logic        row_c     [NUM_ROWS];

    logic [31:0] cap_word  [$];
    logic        cap_right [$];
    logic [31:0] cap_sr;
    logic        bclk_q;
    logic        ws_q;
    integer      seed;

    spdif_rx_top dut (
        .clk               (clk),
        .rst               (rst),
        .signal_i          (line),
        .clk_per_halfbit_i (halfbit),
        .locked_o          (locked),
        .overflow_o        (overflow),
        .udata_o           (udata),
        .cdata_o           (cdata),
        .bclk_o            (bclk),
        .ws_o              (ws),
        .sdata_o           (sdata)
    );

    spdif_source u_source (
        .clk       (clk),
        .rst       (rst),
        .halfbit_i (halfbit),
        .valid_i   (src_valid),
        .pre_i     (src_pre),
        .audio_i   (src_audio),
        .u_i       (src_u),
        .c_i       (src_c),
        .take_o    (src_take),
        .line_o    (line)
    );

    always #50 clk = ~clk;

    // i2s capture on rising bclk
    always @(negedge clk) begin
        bclk_q <= bclk;
        if (bclk && !bclk_q) begin
            cap_sr <= {cap_sr[30:0], sdata};
            ws_q   <= ws;
            if (ws != ws_q) begin  // bit sampled with a ws edge closes the word
                cap_word.push_back({cap_sr[30:0], sdata});
                cap_right.push_back(ws_q);
            end
        end
    end

    task automatic check_value(input string name, input logic [191:0] expected,
                               input logic [191:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "timeout");
    endtask

    task automatic build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_name[i]  = $sformatf("frame %0d", i);
            row_left[i]  = 24'($random(seed));
            row_right[i] = 24'($random(seed));
            row_u[i]     = 1'($random(seed));
            row_c[i]     = 1'($random(seed));
        end
        row_left[0]  = 24'h000000;
        row_right[0] = 24'h000000;
        row_left[1]  = 24'hffffff;
        row_right[1] = 24'hffffff;
        row_left[2]  = 24'h800000;
        row_right[2] = 24'h800000;
    endtask

    // first frame of the block ends up in the msb
    function automatic logic [191:0] expected_status(input logic use_c);
        logic [191:0] v;
        for (int f = 0; f < spdif_pkg::BLOCK_FRAMES; f++) begin
            v[191-f] = use_c ? row_c[f] : row_u[f];
        end
        return v;
    endfunction

    task automatic send_subframe(input spdif_pkg::preamble_e pre, input logic [23:0] audio,
                                 input logic u, input logic c);
        int n;
        @(posedge clk);
        src_pre   <= pre;
        src_audio <= audio;
        src_u     <= u;
        src_c     <= c;
        src_valid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!src_take && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!src_take) begin
            stop_on_timeout("the line encoder to take a subframe");
        end
    endtask

    initial begin
        int n;
        seed      = 39489;
        clk       = 1'b0;
        rst       = 1'b1;
        halfbit   = spdif_pkg::HALFBIT_W'(HALFBIT_CLKS);
        src_valid = 1'b0;
        src_pre   = spdif_pkg::PRE_NONE;
        src_audio = '0;
        src_u     = 1'b0;
        src_c     = 1'b0;
        cap_sr    = '0;
        bclk_q    = 1'b0;
        ws_q      = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("locked after reset", 192'(0), 192'(locked));
        check_value("bclk after reset", 192'(0), 192'(bclk));
        check_value("ws after reset", 192'(0), 192'(ws));
        check_value("sdata after reset", 192'(0), 192'(sdata));

        for (int i = 0; i < NUM_ROWS; i++) begin
            send_subframe((i % spdif_pkg::BLOCK_FRAMES == 0) ? spdif_pkg::PRE_B
                                                              : spdif_pkg::PRE_M,
                          row_left[i], row_u[i], row_c[i]);
            send_subframe(spdif_pkg::PRE_W, row_right[i], row_u[i], row_c[i]);
            if (i == 2) begin
                check_value("lock within three frames", 192'(1), 192'(locked));
            end
            if (i == spdif_pkg::BLOCK_FRAMES) begin
                check_value("channel status", expected_status(1'b1), cdata);
                check_value("user data", expected_status(1'b0), udata);
            end
            check_value("overflow", 192'(0), 192'(overflow));
        end
        @(posedge clk);
        src_valid <= 1'b0;

        // line goes quiet once the last subframe is out
        n = 0;
        @(negedge clk);
        while (locked && n < UNLOCK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (locked) begin
            stop_on_timeout("lock to drop on an idle line");
        end

        n = 0;
        while (cap_word.size() < 2 * NUM_ROWS && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cap_word.size() < 2 * NUM_ROWS) begin
            stop_on_timeout("all i2s words");
        end
        // room for a stray frame after the last word
        repeat (I2S_FRAME_CLKS) @(negedge clk);
        check_value("captured word count", 192'(2 * NUM_ROWS), 192'(cap_word.size()));

        for (int k = 0; k < NUM_ROWS; k++) begin
            check_value({row_name[k], " left"}, 192'({row_left[k], 8'h00}),
                        192'(cap_word[2*k]));
            check_value({row_name[k], " left channel"}, 192'(0), 192'(cap_right[2*k]));
            check_value({row_name[k], " right"}, 192'({row_right[k], 8'h00}),
                        192'(cap_word[2*k+1]));
            check_value({row_name[k], " right channel"}, 192'(1), 192'(cap_right[2*k+1]));
        end
        check_value("overflow at end", 192'(0), 192'(overflow));

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the S/PDIF receiver testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_spdif_rx \
    && ./obj_dir/Vtb_spdif_rx > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/audio_pkg.sv ====
package audio_pkg;

    localparam int SAMPLE_W = 24;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = SAMPLE_W + 1;  // channel bit on top, 1 = right

    // bit clock
    localparam int BCLK_DIV = 2;  // clk cycles per bclk half period
    localparam int BCLK_DIV_W = $clog2(BCLK_DIV + 1);
    localparam logic [BCLK_DIV_W-1:0] BCLK_LAST = BCLK_DIV_W'(BCLK_DIV - 1);

    localparam int I2S_SLOT_W = 32;
    localparam int I2S_FRAME_W = 2 * I2S_SLOT_W;
    localparam int I2S_BIT_W = $clog2(I2S_FRAME_W);

endpackage

// ==== src/i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [audio_pkg::ENTRY_W-1:0] rd_data_i,
    input  logic [audio_pkg::FIFO_AW:0]   count_i,
    output logic                          rd_o,
    output logic                          bclk_o,
    output logic                          ws_o,
    output logic                          sdata_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD_L,
        LOAD_R,
        SHIFT
    } state_e;

    state_e                               state;
    logic [audio_pkg::BCLK_DIV_W-1:0]     div_cnt;
    logic                                 tick;
    logic                                 fall;
    logic [audio_pkg::I2S_BIT_W-1:0]      bit_cnt;
    logic [audio_pkg::I2S_BIT_W-1:0]      bit_nxt;
    logic [audio_pkg::I2S_FRAME_W-1:0]    sr;
    logic [audio_pkg::I2S_SLOT_W-1:0]     slot;
    logic                                 head_right;

    assign head_right = rd_data_i[audio_pkg::ENTRY_W-1];
    assign slot = {rd_data_i[audio_pkg::SAMPLE_W-1:0],
                   {(audio_pkg::I2S_SLOT_W-audio_pkg::SAMPLE_W){1'b0}}};

    assign tick = (div_cnt == audio_pkg::BCLK_LAST);
    assign fall = tick && bclk_o;
    assign bit_nxt = bit_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            bclk_o  <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            bclk_o  <= ~bclk_o;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_comb begin
        case (state)
            IDLE:           rd_o = (count_i != '0) && head_right;  // orphan right, drop
            LOAD_L, LOAD_R: rd_o = 1'b1;
            default:        rd_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            LOAD_L:  sr[audio_pkg::I2S_FRAME_W-1:audio_pkg::I2S_SLOT_W] <= slot;
            LOAD_R:  sr[audio_pkg::I2S_SLOT_W-1:0] <= slot;
            SHIFT:   if (fall) sr <= {sr[audio_pkg::I2S_FRAME_W-2:0], 1'b0};
            default: sr <= sr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
            ws_o    <= 1'b0;
            sdata_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fall) sdata_o <= 1'b0;
                    if (!head_right && count_i > 1) state <= LOAD_L;
                end
                LOAD_L: begin
                    if (fall) sdata_o <= 1'b0;
                    state <= LOAD_R;
                end
                LOAD_R: begin
                    if (fall) sdata_o <= 1'b0;
                    bit_cnt <= '0;
                    state   <= SHIFT;
                end
                default: begin
                    if (fall) begin
                        sdata_o <= sr[audio_pkg::I2S_FRAME_W-1];
                        ws_o    <= bit_nxt[audio_pkg::I2S_BIT_W-1];  // one bit ahead of data
                        bit_cnt <= bit_nxt;
                        if (bit_cnt == '1) state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_i,
    input  logic [audio_pkg::ENTRY_W-1:0] wr_data_i,
    input  logic                          rd_i,
    output logic [audio_pkg::ENTRY_W-1:0] rd_data_o,
    output logic [audio_pkg::FIFO_AW:0]   count_o,
    output logic                          overflow_o
);

    logic [audio_pkg::ENTRY_W-1:0] mem [audio_pkg::FIFO_DEPTH];
    logic [audio_pkg::FIFO_AW-1:0] wr_ptr;
    logic [audio_pkg::FIFO_AW-1:0] rd_ptr;
    logic                          full;
    logic                          empty;
    logic                          do_wr;
    logic                          do_rd;

    assign full = count_o[audio_pkg::FIFO_AW];  // depth is a power of two
    assign empty = (count_o == '0);
    assign do_wr = wr_i && !full;
    assign do_rd = rd_i && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count_o    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
            if (wr_i && full) begin
                overflow_o <= 1'b1;  // sticky
            end
        end
    end

endmodule

// ==== src/spdif_dai.sv ====
`timescale 1ns/1ps

module spdif_dai (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [spdif_pkg::HALFBIT_W-1:0]    clk_per_halfbit_i,
    input  logic                               signal_i,
    output logic [audio_pkg::SAMPLE_W-1:0]     sample_o,
    output logic                               right_o,
    output logic                               ack_o,
    output logic                               locked_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0] udata_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0] cdata_o
);

    logic [3:0]                           lvl_hist;
    logic                                 lvl_change;
    logic [spdif_pkg::HALFBIT_W-1:0]      clk_cnt;
    logic [spdif_pkg::HALFBIT_W-1:0]      high_cnt;
    logic                                 needle;
    logic                                 subbit_ready;
    logic                                 subbit;
    logic [7:0]                           subbit_hist;
    spdif_pkg::preamble_e                 pre;
    logic [spdif_pkg::SUBBIT_W-1:0]       subbit_cnt;
    logic                                 fullbit_prev;
    logic                                 fullbit_ready;
    logic                                 dec_bit;
    logic [audio_pkg::SAMPLE_W-1:0]       bit_hist;
    logic [spdif_pkg::UNLOCK_W-1:0]       unlock_cnt;
    logic                                 audio_done;
    logic                                 aux_done;
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   u_shift;
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   c_shift;

    // line oversampling, an edge needs two stable samples on each side
    always_ff @(posedge clk) begin
        if (rst) begin
            lvl_hist <= '0;
        end else begin
            lvl_hist <= {lvl_hist[2:0], signal_i};
        end
    end

    assign lvl_change = (lvl_hist == 4'b1100) || (lvl_hist == 4'b0011);
    assign needle = lvl_hist[1];

    // half-bit timer, restarted by every line edge
    assign subbit_ready = (clk_cnt == clk_per_halfbit_i) || lvl_change;

    always_ff @(posedge clk) begin
        if (rst || subbit_ready) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // majority vote over the half-bit
    always_ff @(posedge clk) begin
        if (rst) begin
            high_cnt <= '0;
        end else if (subbit_ready) begin
            high_cnt <= {{(spdif_pkg::HALFBIT_W-1){1'b0}}, needle};
        end else begin
            high_cnt <= high_cnt + {{(spdif_pkg::HALFBIT_W-1){1'b0}}, needle};
        end
    end

    assign subbit = (high_cnt >= (clk_per_halfbit_i >> 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            subbit_hist <= '0;
        end else if (subbit_ready) begin
            subbit_hist <= {subbit_hist[6:0], subbit};
        end
    end

    always_comb begin
        case (subbit_hist)
            spdif_pkg::SYNC_B, ~spdif_pkg::SYNC_B: pre = spdif_pkg::PRE_B;
            spdif_pkg::SYNC_M, ~spdif_pkg::SYNC_M: pre = spdif_pkg::PRE_M;
            spdif_pkg::SYNC_W, ~spdif_pkg::SYNC_W: pre = spdif_pkg::PRE_W;
            default:                               pre = spdif_pkg::PRE_NONE;
        endcase
    end

    // half-bits since the last preamble, parks at SUBBIT_UNLOCKED
    always_ff @(posedge clk) begin
        if (rst) begin
            subbit_cnt <= spdif_pkg::SUBBIT_UNLOCKED;
        end else if (subbit_ready) begin
            if (pre != spdif_pkg::PRE_NONE) begin
                subbit_cnt <= '0;
            end else if (subbit_cnt != spdif_pkg::SUBBIT_UNLOCKED) begin
                subbit_cnt <= subbit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            right_o <= 1'b0;
        end else if (subbit_ready && pre != spdif_pkg::PRE_NONE) begin
            right_o <= (pre == spdif_pkg::PRE_W);
        end
    end

    // a full cell is in the history once the count turns odd
    always_ff @(posedge clk) begin
        if (rst) begin
            fullbit_prev <= 1'b0;
        end else begin
            fullbit_prev <= subbit_cnt[0];
        end
    end

    assign fullbit_ready = subbit_cnt[0] && !fullbit_prev;
    assign dec_bit = subbit_hist[1] ^ subbit_hist[0];  // mid-cell transition is a one

    always_ff @(posedge clk) begin
        if (fullbit_ready) begin
            bit_hist <= {dec_bit, bit_hist[audio_pkg::SAMPLE_W-1:1]};  // lsb first
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            unlock_cnt <= spdif_pkg::UNLOCK_TOLERANCE;
        end else if (subbit_cnt != spdif_pkg::SUBBIT_UNLOCKED) begin
            unlock_cnt <= '0;
        end else if (unlock_cnt != spdif_pkg::UNLOCK_TOLERANCE) begin
            unlock_cnt <= unlock_cnt + 1'b1;
        end
    end

    assign locked_o = (unlock_cnt != spdif_pkg::UNLOCK_TOLERANCE);

    assign audio_done = subbit_ready && (subbit_cnt == spdif_pkg::AUDIO_END_HALFBIT);
    assign aux_done = subbit_ready && (subbit_cnt == spdif_pkg::AUX_END_HALFBIT);

    always_ff @(posedge clk) begin
        if (audio_done) begin
            sample_o <= bit_hist;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= audio_done && locked_o;
        end
    end

    // bit_hist now holds slots 8..31, p on top, then c, u, v
    // one status bit per frame, taken from the left subframe
    always_ff @(posedge clk) begin
        if (aux_done && !right_o) begin
            u_shift <= {u_shift[spdif_pkg::BLOCK_FRAMES-2:0], bit_hist[audio_pkg::SAMPLE_W-3]};
            c_shift <= {c_shift[spdif_pkg::BLOCK_FRAMES-2:0], bit_hist[audio_pkg::SAMPLE_W-2]};
        end
    end

    always_ff @(posedge clk) begin
        if (subbit_ready && pre == spdif_pkg::PRE_B) begin
            udata_o <= u_shift;
            cdata_o <= c_shift;
        end
    end

endmodule

// ==== src/spdif_pkg.sv ====
package spdif_pkg;

    localparam int HALFBIT_W = 5;  // half-bit length input, up to 31 clocks

    // subframe geometry in half-bits, counted from the end of the preamble
    localparam int SUBFRAME_HALFBITS = 64;
    localparam int SUBBIT_W = $clog2(SUBFRAME_HALFBITS);
    localparam logic [SUBBIT_W-1:0] SUBBIT_UNLOCKED = SUBBIT_W'(SUBFRAME_HALFBITS - 1);
    localparam logic [SUBBIT_W-1:0] AUDIO_END_HALFBIT = SUBBIT_W'(48);  // aux + audio, 24 bits
    localparam logic [SUBBIT_W-1:0] AUX_END_HALFBIT = SUBBIT_W'(56);    // v, u, c, p done

    localparam int BLOCK_FRAMES = 192;

    // clocks spent at SUBBIT_UNLOCKED before lock drops
    localparam int UNLOCK_W = 3;
    localparam logic [UNLOCK_W-1:0] UNLOCK_TOLERANCE = UNLOCK_W'(6);

    typedef enum logic [1:0] {
        PRE_NONE,
        PRE_B,     // left, first frame of a block
        PRE_M,     // left
        PRE_W      // right
    } preamble_e;

    // half-bit patterns, oldest half-bit in the msb
    // the inverted patterns are valid as well, polarity depends on the previous cell
    localparam logic [7:0] SYNC_B = 8'b0001_0111;
    localparam logic [7:0] SYNC_W = 8'b0001_1011;
    localparam logic [7:0] SYNC_M = 8'b0001_1101;

endpackage

// ==== src/spdif_rx_top.sv ====
`timescale 1ns/1ps

module spdif_rx_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               signal_i,
    input  logic [spdif_pkg::HALFBIT_W-1:0]    clk_per_halfbit_i,
    output logic                               locked_o,
    output logic                               overflow_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0] udata_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0] cdata_o,
    output logic                               bclk_o,
    output logic                               ws_o,
    output logic                               sdata_o
);

    logic [audio_pkg::SAMPLE_W-1:0] dai_sample;
    logic                           dai_right;
    logic                           dai_ack;
    logic [audio_pkg::ENTRY_W-1:0]  fifo_rd_data;
    logic [audio_pkg::FIFO_AW:0]    fifo_count;
    logic                           fifo_rd;

    spdif_dai u_dai (
        .clk               (clk),
        .rst               (rst),
        .clk_per_halfbit_i (clk_per_halfbit_i),
        .signal_i          (signal_i),
        .sample_o          (dai_sample),
        .right_o           (dai_right),
        .ack_o             (dai_ack),
        .locked_o          (locked_o),
        .udata_o           (udata_o),
        .cdata_o           (cdata_o)
    );

    // entries carry the channel next to the sample
    sample_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (dai_ack),
        .wr_data_i  ({dai_right, dai_sample}),
        .rd_i       (fifo_rd),
        .rd_data_o  (fifo_rd_data),
        .count_o    (fifo_count),
        .overflow_o (overflow_o)
    );

    i2s_tx u_i2s (
        .clk       (clk),
        .rst       (rst),
        .rd_data_i (fifo_rd_data),
        .count_i   (fifo_count),
        .rd_o      (fifo_rd),
        .bclk_o    (bclk_o),
        .ws_o      (ws_o),
        .sdata_o   (sdata_o)
    );

endmodule

// ==== tb.f ====
src/spdif_pkg.sv
src/audio_pkg.sv
src/spdif_dai.sv
src/sample_fifo.sv
src/i2s_tx.sv
src/spdif_rx_top.sv
bench/spdif_source.sv
bench/spdif_rx_assert.sv
bench/tb_spdif_rx.sv
